/* design/pr_region_pkg.sv */
package pr_region_pkg;

   localparam int NUM_PERSONA = 2;
   localparam int DATA_W      = 32;
   localparam int ADDR_W      = 16;

   typedef logic [$clog2(NUM_PERSONA)-1:0] persona_sel_t;
   typedef logic [DATA_W-1:0]              data_t;
   typedef logic [ADDR_W-1:0]              addr_t;

   localparam persona_sel_t ARITH_SEL    = 1'b0;
   localparam persona_sel_t CHECKSUM_SEL = 1'b1;

   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_XOR = 2'd3
   } opcode_t;

   // Arithmetic persona register map
   localparam addr_t REG_OPERAND_A  = 16'd0;
   localparam addr_t REG_OPERAND_B  = 16'd1;
   localparam addr_t REG_OPCODE     = 16'd2;
   localparam addr_t REG_RESULT     = 16'd3;

   // Checksum persona register map
   localparam addr_t REG_DATA_IN    = 16'd0;
   localparam addr_t REG_SUM        = 16'd1;
   localparam addr_t REG_COUNT      = 16'd2;

   localparam addr_t REG_PERSONA_ID = 16'd15;
   localparam data_t ARITH_ID       = 32'h00A1_0001;
   localparam data_t CHECKSUM_ID    = 32'h00C5_0002;

endpackage

/* design/pr_handshake_ctrl.sv */
`timescale 1ns/10ps

module pr_handshake_ctrl (
   input  logic pr_region_clk,
   input  logic arst_n,
   input  logic start_req,
   input  logic stop_req,
   input  logic read_pending,
   output logic start_ack,
   output logic stop_ack,
   output logic freeze
);

   typedef enum logic {
      ST_FROZEN,
      ST_RUNNING
   } state_t;

   state_t state;

   always_ff @(posedge pr_region_clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_FROZEN;
         start_ack <= 1'b0;
         stop_ack  <= 1'b0;
      end else begin
         case (state)
            ST_FROZEN: begin
               if (start_req) begin
                  state     <= ST_RUNNING;
                  start_ack <= 1'b1;
               end
            end
            ST_RUNNING: begin
               // A read accepted this cycle still owes its response
               if (stop_req && !read_pending) begin
                  state    <= ST_FROZEN;
                  stop_ack <= 1'b1;
               end
            end
            default: begin
               state <= ST_FROZEN;
            end
         endcase
         // Acks fall one cycle after their request drops
         if (!start_req) begin
            start_ack <= 1'b0;
         end
         if (!stop_req) begin
            stop_ack <= 1'b0;
         end
      end
   end

   assign freeze = (state == ST_FROZEN);

endmodule

/* design/persona_router.sv */
`timescale 1ns/10ps

module persona_router
   import pr_region_pkg::*;
(
   input  persona_sel_t persona_sel,
   input  logic         pr_activate,
   input  logic         read,
   input  logic         write,
   input  logic         start_req,
   input  logic         stop_req,
   output logic         persona_read [NUM_PERSONA],
   output logic         persona_write [NUM_PERSONA],
   output logic         persona_start_req [NUM_PERSONA],
   output logic         persona_stop_req [NUM_PERSONA],
   input  logic         persona_waitrequest [NUM_PERSONA],
   input  logic         persona_readdatavalid [NUM_PERSONA],
   input  logic         persona_start_ack [NUM_PERSONA],
   input  logic         persona_stop_ack [NUM_PERSONA],
   input  logic         persona_freeze [NUM_PERSONA],
   input  data_t        persona_readdata [NUM_PERSONA],
   output logic         waitrequest,
   output data_t        readdata,
   output logic         readdatavalid,
   output logic         start_ack,
   output logic         stop_ack,
   output logic         freeze
);

   logic [NUM_PERSONA-1:0] owner;

   // No persona owns the region while it is being reconfigured
   always_comb begin
      for (int i = 0; i < NUM_PERSONA; i++) begin
         owner[i] = !pr_activate && (persona_sel == persona_sel_t'(i));
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_PERSONA; i++) begin
         persona_read[i]      = read && owner[i];
         persona_write[i]     = write && owner[i];
         persona_start_req[i] = start_req && owner[i];
         persona_stop_req[i]  = stop_req && owner[i];
      end
   end

   // Safe idle values toward the host during pr_activate
   always_comb begin
      if (pr_activate) begin
         waitrequest   = 1'b1;
         readdata      = '0;
         readdatavalid = 1'b0;
         start_ack     = 1'b0;
         stop_ack      = 1'b0;
         freeze        = 1'b1;
      end else begin
         waitrequest   = persona_waitrequest[persona_sel];
         readdata      = persona_readdata[persona_sel];
         readdatavalid = persona_readdatavalid[persona_sel];
         start_ack     = persona_start_ack[persona_sel];
         stop_ack      = persona_stop_ack[persona_sel];
         freeze        = persona_freeze[persona_sel];
      end
   end

endmodule

/* design/arith_persona.sv */
`timescale 1ns/10ps

module arith_persona
   import pr_region_pkg::*;
(
   input  logic  pr_region_clk,
   input  logic  arst_n,
   input  logic  read,
   input  logic  write,
   input  addr_t address,
   input  data_t writedata,
   input  logic  start_req,
   input  logic  stop_req,
   output logic  waitrequest,
   output data_t readdata,
   output logic  readdatavalid,
   output logic  start_ack,
   output logic  stop_ack,
   output logic  freeze
);

   logic    rd_accept;
   logic    wr_accept;
   data_t   operand_a;
   data_t   operand_b;
   opcode_t opcode;
   data_t   result;
   data_t   rd_mux;

   pr_handshake_ctrl u_handshake (
      .pr_region_clk (pr_region_clk),
      .arst_n        (arst_n),
      .start_req     (start_req),
      .stop_req      (stop_req),
      .read_pending  (rd_accept),
      .start_ack     (start_ack),
      .stop_ack      (stop_ack),
      .freeze        (freeze)
   );

   // Requests are held off for as long as the persona is frozen
   assign waitrequest = freeze;
   assign rd_accept   = read && !waitrequest;
   assign wr_accept   = write && !waitrequest;

   always_ff @(posedge pr_region_clk) begin
      if (wr_accept && address == REG_OPERAND_A) begin
         operand_a <= writedata;
      end
      if (wr_accept && address == REG_OPERAND_B) begin
         operand_b <= writedata;
      end
   end

   always_ff @(posedge pr_region_clk or negedge arst_n) begin
      if (!arst_n) begin
         opcode <= OP_ADD;
      end else if (wr_accept && address == REG_OPCODE) begin
         opcode <= opcode_t'(writedata[1:0]);
      end
   end

   // MUL keeps the low word of the product
   always_comb begin
      case (opcode)
         OP_ADD:  result = operand_a + operand_b;
         OP_SUB:  result = operand_a - operand_b;
         OP_MUL:  result = operand_a * operand_b;
         OP_XOR:  result = operand_a ^ operand_b;
         default: result = '0;
      endcase
   end

   always_comb begin
      case (address)
         REG_OPERAND_A:  rd_mux = operand_a;
         REG_OPERAND_B:  rd_mux = operand_b;
         REG_OPCODE:     rd_mux = data_t'(opcode);
         REG_RESULT:     rd_mux = result;
         REG_PERSONA_ID: rd_mux = ARITH_ID;
         default:        rd_mux = '0;
      endcase
   end

   always_ff @(posedge pr_region_clk or negedge arst_n) begin
      if (!arst_n) begin
         readdatavalid <= 1'b0;
         readdata      <= '0;
      end else begin
         readdatavalid <= rd_accept;
         readdata      <= rd_accept ? rd_mux : '0;
      end
   end

endmodule

/* design/checksum_persona.sv */
`timescale 1ns/10ps

module checksum_persona
   import pr_region_pkg::*;
(
   input  logic  pr_region_clk,
   input  logic  arst_n,
   input  logic  read,
   input  logic  write,
   input  addr_t address,
   input  data_t writedata,
   input  logic  start_req,
   input  logic  stop_req,
   output logic  waitrequest,
   output data_t readdata,
   output logic  readdatavalid,
   output logic  start_ack,
   output logic  stop_ack,
   output logic  freeze
);

   logic  rd_accept;
   logic  wr_accept;
   data_t sum;
   data_t count;
   data_t rd_mux;

   pr_handshake_ctrl u_handshake (
      .pr_region_clk (pr_region_clk),
      .arst_n        (arst_n),
      .start_req     (start_req),
      .stop_req      (stop_req),
      .read_pending  (rd_accept),
      .start_ack     (start_ack),
      .stop_ack      (stop_ack),
      .freeze        (freeze)
   );

   assign waitrequest = freeze;
   assign rd_accept   = read && !waitrequest;
   assign wr_accept   = write && !waitrequest;

   // Sum wraps at 32 bits and a write to REG_SUM clears it with the count
   always_ff @(posedge pr_region_clk or negedge arst_n) begin
      if (!arst_n) begin
         sum   <= '0;
         count <= '0;
      end else if (wr_accept && address == REG_DATA_IN) begin
         sum   <= sum + writedata;
         count <= count + data_t'(1);
      end else if (wr_accept && address == REG_SUM) begin
         sum   <= '0;
         count <= '0;
      end
   end

   // REG_DATA_IN reads back as zero
   always_comb begin
      case (address)
         REG_SUM:        rd_mux = sum;
         REG_COUNT:      rd_mux = count;
         REG_PERSONA_ID: rd_mux = CHECKSUM_ID;
         default:        rd_mux = '0;
      endcase
   end

   always_ff @(posedge pr_region_clk or negedge arst_n) begin
      if (!arst_n) begin
         readdatavalid <= 1'b0;
         readdata      <= '0;
      end else begin
         readdatavalid <= rd_accept;
         readdata      <= rd_accept ? rd_mux : '0;
      end
   end

endmodule

/* design/pr_region_wrapper.sv */
`timescale 1ns/10ps

module pr_region_wrapper
   import pr_region_pkg::*;
(
   input  logic         pr_region_clk,
   input  logic         arst_n,
   input  persona_sel_t persona_sel,
   input  logic         pr_activate,
   input  logic         read,
   input  logic         write,
   input  addr_t        address,
   input  data_t        writedata,
   output logic         waitrequest,
   output data_t        readdata,
   output logic         readdatavalid,
   input  logic         start_req,
   input  logic         stop_req,
   output logic         start_ack,
   output logic         stop_ack,
   output logic         freeze
);

   logic  persona_read [NUM_PERSONA];
   logic  persona_write [NUM_PERSONA];
   logic  persona_start_req [NUM_PERSONA];
   logic  persona_stop_req [NUM_PERSONA];
   logic  persona_waitrequest [NUM_PERSONA];
   logic  persona_readdatavalid [NUM_PERSONA];
   logic  persona_start_ack [NUM_PERSONA];
   logic  persona_stop_ack [NUM_PERSONA];
   logic  persona_freeze [NUM_PERSONA];
   data_t persona_readdata [NUM_PERSONA];

   persona_router u_router (
      .persona_sel           (persona_sel),
      .pr_activate           (pr_activate),
      .read                  (read),
      .write                 (write),
      .start_req             (start_req),
      .stop_req              (stop_req),
      .persona_read          (persona_read),
      .persona_write         (persona_write),
      .persona_start_req     (persona_start_req),
      .persona_stop_req      (persona_stop_req),
      .persona_waitrequest   (persona_waitrequest),
      .persona_readdatavalid (persona_readdatavalid),
      .persona_start_ack     (persona_start_ack),
      .persona_stop_ack      (persona_stop_ack),
      .persona_freeze        (persona_freeze),
      .persona_readdata      (persona_readdata),
      .waitrequest           (waitrequest),
      .readdata              (readdata),
      .readdatavalid         (readdatavalid),
      .start_ack             (start_ack),
      .stop_ack              (stop_ack),
      .freeze                (freeze)
   );

   arith_persona u_arith_persona (
      .pr_region_clk (pr_region_clk),
      .arst_n        (arst_n),
      .read          (persona_read[ARITH_SEL]),
      .write         (persona_write[ARITH_SEL]),
      .address       (address),
      .writedata     (writedata),
      .start_req     (persona_start_req[ARITH_SEL]),
      .stop_req      (persona_stop_req[ARITH_SEL]),
      .waitrequest   (persona_waitrequest[ARITH_SEL]),
      .readdata      (persona_readdata[ARITH_SEL]),
      .readdatavalid (persona_readdatavalid[ARITH_SEL]),
      .start_ack     (persona_start_ack[ARITH_SEL]),
      .stop_ack      (persona_stop_ack[ARITH_SEL]),
      .freeze        (persona_freeze[ARITH_SEL])
   );

   checksum_persona u_checksum_persona (
      .pr_region_clk (pr_region_clk),
      .arst_n        (arst_n),
      .read          (persona_read[CHECKSUM_SEL]),
      .write         (persona_write[CHECKSUM_SEL]),
      .address       (address),
      .writedata     (writedata),
      .start_req     (persona_start_req[CHECKSUM_SEL]),
      .stop_req      (persona_stop_req[CHECKSUM_SEL]),
      .waitrequest   (persona_waitrequest[CHECKSUM_SEL]),
      .readdata      (persona_readdata[CHECKSUM_SEL]),
      .readdatavalid (persona_readdatavalid[CHECKSUM_SEL]),
      .start_ack     (persona_start_ack[CHECKSUM_SEL]),
      .stop_ack      (persona_stop_ack[CHECKSUM_SEL]),
      .freeze        (persona_freeze[CHECKSUM_SEL])
   );

endmodule

/* verif/pr_region_wrapper_tb.sv */
`timescale 1ns/10ps

module pr_region_wrapper_tb
   import pr_region_pkg::*;
();

   localparam int NUM_TESTS = 5;
   localparam int MAX_WAIT  = 20;

   logic         pr_region_clk = 1'b0;
   logic         arst_n;
   persona_sel_t persona_sel;
   logic         pr_activate;
   logic         read;
   logic         write;
   addr_t        address;
   data_t        writedata;
   logic         waitrequest;
   data_t        readdata;
   logic         readdatavalid;
   logic         start_req;
   logic         stop_req;
   logic         start_ack;
   logic         stop_ack;
   logic         freeze;

   integer seed   = 28;
   int     errors = 0;
   int     checks = 0;

   always #4 pr_region_clk = ~pr_region_clk;

   pr_region_wrapper pr_region_wrapper_i (.*);

   task automatic check_data(input string name, input data_t actual, input data_t expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic next_cycle();
      @(posedge pr_region_clk);
      #1;
   endtask

   // Returns at the falling edge just before the accepting rising edge
   task automatic wait_accept(input string what);
      int n;
      n = 0;
      @(negedge pr_region_clk);
      while (waitrequest && n < MAX_WAIT) begin
         next_cycle();
         @(negedge pr_region_clk);
         n++;
      end
      if (waitrequest) begin
         errors++;
         $display("The %s request was never accepted, waitrequest stayed high", what);
      end
   endtask

   task automatic wait_ack(input logic is_stop, input logic level);
      int n;
      n = 0;
      @(negedge pr_region_clk);
      while ((is_stop ? stop_ack : start_ack) !== level && n < MAX_WAIT) begin
         @(negedge pr_region_clk);
         n++;
      end
      if ((is_stop ? stop_ack : start_ack) !== level) begin
         errors++;
         $display("The %s acknowledge did not go %s in time",
                  is_stop ? "stop" : "start", level ? "high" : "low");
      end
   endtask

   task automatic bus_write(input addr_t addr, input data_t data);
      write     = 1'b1;
      address   = addr;
      writedata = data;
      wait_accept("write");
      next_cycle();
      write = 1'b0;
   endtask

   task automatic bus_read(input addr_t addr, output data_t data);
      read    = 1'b1;
      address = addr;
      wait_accept("read");
      check_bit("readdatavalid", readdatavalid, 1'b0);
      next_cycle();
      read = 1'b0;
      @(negedge pr_region_clk);
      check_bit("readdatavalid", readdatavalid, 1'b1);
      data = readdata;
      @(negedge pr_region_clk);
      check_bit("readdatavalid", readdatavalid, 1'b0);
      check_data("readdata", readdata, '0);
      next_cycle();
   endtask

   task automatic pr_start();
      start_req = 1'b1;
      wait_ack(1'b0, 1'b1);
      check_bit("freeze", freeze, 1'b0);
      check_bit("waitrequest", waitrequest, 1'b0);
      next_cycle();
      start_req = 1'b0;
      wait_ack(1'b0, 1'b0);
      next_cycle();
   endtask

   task automatic pr_stop();
      stop_req = 1'b1;
      wait_ack(1'b1, 1'b1);
      check_bit("freeze", freeze, 1'b1);
      check_bit("waitrequest", waitrequest, 1'b1);
      next_cycle();
      stop_req = 1'b0;
      wait_ack(1'b1, 1'b0);
      next_cycle();
   endtask

   task automatic set_persona(input persona_sel_t sel);
      pr_activate = 1'b1;
      @(negedge pr_region_clk);
      check_bit("waitrequest", waitrequest, 1'b1);
      check_bit("freeze", freeze, 1'b1);
      next_cycle();
      persona_sel = sel;
      next_cycle();
      pr_activate = 1'b0;
   endtask

   // A held read waits for the start, then pr_activate masks both answers
   task automatic start_then_mask_outputs();
      start_req = 1'b1;
      read      = 1'b1;
      address   = REG_PERSONA_ID;
      wait_ack(1'b0, 1'b1);
      check_bit("readdatavalid", readdatavalid, 1'b0);
      check_bit("waitrequest", waitrequest, 1'b0);
      next_cycle();
      read        = 1'b0;
      pr_activate = 1'b1;
      @(negedge pr_region_clk);
      check_bit("start_ack", start_ack, 1'b0);
      check_bit("readdatavalid", readdatavalid, 1'b0);
      check_data("readdata", readdata, '0);
      check_bit("waitrequest", waitrequest, 1'b1);
      check_bit("freeze", freeze, 1'b1);
      next_cycle();
      start_req   = 1'b0;
      pr_activate = 1'b0;
      wait_ack(1'b0, 1'b0);
      next_cycle();
   endtask

   task automatic hold_read_blocked(input int cycles);
      read    = 1'b1;
      address = REG_PERSONA_ID;
      repeat (cycles) begin
         @(negedge pr_region_clk);
         check_bit("waitrequest", waitrequest, 1'b1);
         check_bit("readdatavalid", readdatavalid, 1'b0);
         next_cycle();
      end
      read = 1'b0;
   endtask

   task automatic reset_idle_values();
      @(negedge pr_region_clk);
      check_bit("freeze", freeze, 1'b1);
      check_bit("waitrequest", waitrequest, 1'b1);
      check_bit("start_ack", start_ack, 1'b0);
      check_bit("stop_ack", stop_ack, 1'b0);
      check_bit("readdatavalid", readdatavalid, 1'b0);
      next_cycle();
      // A start request must not reach a persona during reconfiguration
      pr_activate = 1'b1;
      start_req   = 1'b1;
      repeat (3) begin
         @(negedge pr_region_clk);
         check_bit("start_ack", start_ack, 1'b0);
         check_bit("freeze", freeze, 1'b1);
         check_bit("waitrequest", waitrequest, 1'b1);
         next_cycle();
      end
      start_req   = 1'b0;
      pr_activate = 1'b0;
      hold_read_blocked(4);
   endtask

   task automatic start_and_identity();
      data_t d;
      set_persona(ARITH_SEL);
      start_then_mask_outputs();
      bus_read(REG_PERSONA_ID, d);
      check_data("readdata (REG_PERSONA_ID)", d, ARITH_ID);
      set_persona(CHECKSUM_SEL);
      pr_start();
      bus_read(REG_PERSONA_ID, d);
      check_data("readdata (REG_PERSONA_ID)", d, CHECKSUM_ID);
   endtask

   task automatic arithmetic_ops();
      data_t   a;
      data_t   b;
      data_t   d;
      data_t   expected;
      opcode_t op;
      set_persona(ARITH_SEL);
      for (int k = 0; k < 4; k++) begin
         a  = data_t'($random(seed));
         b  = data_t'($random(seed));
         op = opcode_t'(k);
         case (op)
            OP_ADD:  expected = a + b;
            OP_SUB:  expected = a - b;
            OP_MUL:  expected = a * b;
            default: expected = a ^ b;
         endcase
         bus_write(REG_OPERAND_A, a);
         bus_write(REG_OPERAND_B, b);
         bus_write(REG_OPCODE, data_t'(op));
         bus_read(REG_RESULT, d);
         check_data("readdata (REG_RESULT)", d, expected);
      end
      bus_read(16'h0007, d);
      check_data("readdata (unmapped)", d, '0);
   endtask

   task automatic checksum_sum_count();
      data_t w;
      data_t expected_sum;
      set_persona(CHECKSUM_SEL);
      bus_write(REG_SUM, '0);
      expected_sum = '0;
      repeat (10) begin
         w            = data_t'($random(seed));
         expected_sum = expected_sum + w;
         bus_write(REG_DATA_IN, w);
      end
      // Two reads back to back, one response per cycle
      read    = 1'b1;
      address = REG_SUM;
      wait_accept("read");
      next_cycle();
      address = REG_COUNT;
      @(negedge pr_region_clk);
      check_bit("readdatavalid", readdatavalid, 1'b1);
      check_data("readdata (REG_SUM)", readdata, expected_sum);
      next_cycle();
      read = 1'b0;
      @(negedge pr_region_clk);
      check_bit("readdatavalid", readdatavalid, 1'b1);
      check_data("readdata (REG_COUNT)", readdata, 32'd10);
      @(negedge pr_region_clk);
      check_bit("readdatavalid", readdatavalid, 1'b0);
      next_cycle();
   endtask

   task automatic stop_isolation_retention();
      data_t a;
      data_t b;
      data_t d;
      a = data_t'($random(seed));
      b = data_t'($random(seed));
      set_persona(ARITH_SEL);
      bus_write(REG_OPERAND_A, a);
      bus_write(REG_OPERAND_B, b);
      bus_write(REG_OPCODE, data_t'(OP_XOR));
      // Same addresses, now owned by the checksum persona
      set_persona(CHECKSUM_SEL);
      bus_write(REG_OPERAND_A, ~a);
      bus_write(REG_OPERAND_B, ~b);
      set_persona(ARITH_SEL);
      bus_read(REG_OPERAND_A, d);
      check_data("readdata (REG_OPERAND_A)", d, a);
      bus_read(REG_OPERAND_B, d);
      check_data("readdata (REG_OPERAND_B)", d, b);
      pr_stop();
      hold_read_blocked(4);
      pr_start();
      bus_read(REG_OPERAND_A, d);
      check_data("readdata (REG_OPERAND_A)", d, a);
      bus_read(REG_OPERAND_B, d);
      check_data("readdata (REG_OPERAND_B)", d, b);
      bus_read(REG_OPCODE, d);
      check_data("readdata (REG_OPCODE)", d, data_t'(OP_XOR));
      bus_read(REG_RESULT, d);
      check_data("readdata (REG_RESULT)", d, a ^ b);
   endtask

   initial begin
      arst_n      = 1'b0;
      persona_sel = ARITH_SEL;
      pr_activate = 1'b0;
      read        = 1'b0;
      write       = 1'b0;
      address     = '0;
      writedata   = '0;
      start_req   = 1'b0;
      stop_req    = 1'b0;
      repeat (8) @(posedge pr_region_clk);
      #1;
      arst_n = 1'b1;
      reset_idle_values();
      start_and_identity();
      arithmetic_ops();
      checksum_sum_count();
      stop_isolation_retention();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(NUM_TESTS * 200 * 8);
      $display("Timeout: the tests did not finish within %0d ns", NUM_TESTS * 200 * 8);
      $display("checks %0d, errors %0d", checks, errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* pr_region_wrapper.f */
design/pr_region_pkg.sv
design/pr_handshake_ctrl.sv
design/persona_router.sv
design/arith_persona.sv
design/checksum_persona.sv
design/pr_region_wrapper.sv
verif/pr_region_wrapper_tb.sv

/* Makefile */
TOP := pr_region_wrapper_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f pr_region_wrapper.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
